// ==== src/des_key_types_pkg.sv ====
package des_key_types_pkg;

	localparam int key_width = 64;         // User key with its eight parity bits
	localparam int half_width = 28;        // One of the C or D halves
	localparam int cd_width = 2 * half_width;
	localparam int round_key_width = 48;
	localparam int round_count = 16;

	// Vectors are numbered from 1 at the left, the same way the DES tables count bits
	typedef logic [1:key_width] user_key_t;

	// C occupies bits 1 to 28 and D occupies bits 29 to 56
	typedef logic [1:cd_width] cd_key_t;

	typedef logic [1:round_key_width] round_key_t;

	// Slot 1 is the leftmost and most significant key of the bank
	typedef round_key_t [1:round_count] round_key_bank_t;

endpackage

// ==== src/des_key_tables_pkg.sv ====
package des_key_tables_pkg;

	import des_key_types_pkg::*;

	// Permuted choice 1. Entry i names the user key bit that becomes bit i of C and D
	// Bits 8, 16 and so on up to 64 never appear, which is how parity gets dropped
	localparam int pc1_table [1:cd_width] = '{
		57, 49, 41, 33, 25, 17,  9,
		 1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27,
		19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		 7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29,
		21, 13,  5, 28, 20, 12,  4
	};

	// Permuted choice 2. Entry i names the bit of the rotated C and D for key bit i
	localparam int pc2_table [1:round_key_width] = '{
		14, 17, 11, 24,  1,  5,
		 3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8,
		16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	// Left rotations per round when encrypting. They add up to 28, one full turn
	localparam int enc_shift_table [1:round_count] = '{
		1, 1, 2, 2, 2, 2, 2, 2,
		1, 2, 2, 2, 2, 2, 2, 1
	};

	// Right rotations per round when decrypting
	// Round 1 starts from C0 and D0, which already equal C16 and D16, so it does
	// not rotate; round i then undoes encrypt round 18 - i
	localparam int dec_shift_table [1:round_count] = '{
		0, 1, 2, 2, 2, 2, 2, 2,
		1, 2, 2, 2, 2, 2, 2, 1
	};

endpackage

// ==== src/key_select_pc1.sv ====
`timescale 1ns/1ps

module key_select_pc1
	import des_key_types_pkg::*;
	import des_key_tables_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic key_load,
	input logic key_decrypt,
	input user_key_t user_key,
	output cd_key_t cd_out,
	output logic decrypt_out,
	output logic valid_out
);

	cd_key_t pc1_sel;

	// PC-1 is pure wiring, so a loop over the table is enough
	always_comb begin
		for (int i = 1; i <= cd_width; i++) begin
			pc1_sel[i] = user_key[pc1_table[i]];
		end
	end

	// The key and its direction are held until the next load
	always_ff @(posedge clk) begin
		if (key_load) begin
			cd_out <= pc1_sel;
			decrypt_out <= key_decrypt;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= key_load;  // One valid per load strobe
		end
	end

endmodule

// ==== src/key_round_stage.sv ====
`timescale 1ns/1ps

module key_round_stage
	import des_key_types_pkg::*;
	import des_key_tables_pkg::*;
#(
	parameter int round = 1
) (
	input logic clk,
	input logic reset,
	input cd_key_t cd_in,
	input logic decrypt_in,
	input logic valid_in,
	output cd_key_t cd_out,
	output logic decrypt_out,
	output logic valid_out,
	output round_key_t round_key
);

	localparam int enc_shift = enc_shift_table[round];
	localparam int dec_shift = dec_shift_table[round];

	logic [1:half_width] c_in;
	logic [1:half_width] d_in;
	logic [1:half_width] c_rot;
	logic [1:half_width] d_rot;
	cd_key_t cd_rot;
	round_key_t key_sel;

	assign c_in = cd_in[1:half_width];
	assign d_in = cd_in[half_width + 1:cd_width];

	// Bit 1 is the MSB, so a DES left rotation is a shift toward bit 1.
	// A zero shift also works here since shifting by the full width gives zero
	always_comb begin
		if (decrypt_in) begin
			c_rot = (c_in >> dec_shift) | (c_in << (half_width - dec_shift));
			d_rot = (d_in >> dec_shift) | (d_in << (half_width - dec_shift));
		end else begin
			c_rot = (c_in << enc_shift) | (c_in >> (half_width - enc_shift));
			d_rot = (d_in << enc_shift) | (d_in >> (half_width - enc_shift));
		end
	end

	assign cd_rot = {c_rot, d_rot};

	// PC-2 picks 48 of the 56 rotated bits for this round's key
	always_comb begin
		for (int i = 1; i <= round_key_width; i++) begin
			key_sel[i] = cd_rot[pc2_table[i]];
		end
	end

	always_ff @(posedge clk) begin
		cd_out <= cd_rot;             // Next stage rotates from here
		decrypt_out <= decrypt_in;
		round_key <= key_sel;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

endmodule

// ==== src/round_key_collect.sv ====
`timescale 1ns/1ps

module round_key_collect
	import des_key_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input round_key_bank_t stage_keys,
	input logic stage16_valid,
	output round_key_bank_t round_keys,
	output logic keys_valid
);

	// Stage k finishes 16 - k cycles ahead of stage 16, so slot k waits that long
	for (genvar k = 1; k <= round_count; k++) begin : g_slot
		localparam int depth = round_count - k;

		if (depth == 0) begin : g_direct
			assign round_keys[k] = stage_keys[k];  // Last stage is already aligned
		end else begin : g_delay
			round_key_t delay_q [1:depth];

			always_ff @(posedge clk) begin
				if (reset) begin
					for (int i = 1; i <= depth; i++) begin
						delay_q[i] <= '0;
					end
				end else begin
					delay_q[1] <= stage_keys[k];
					for (int i = 2; i <= depth; i++) begin
						delay_q[i] <= delay_q[i - 1];
					end
				end
			end

			assign round_keys[k] = delay_q[depth];
		end
	end

	// All slots now line up with stage 16, so its valid marks the whole bank
	assign keys_valid = stage16_valid;

endmodule

// ==== src/des_key_schedule.sv ====
`timescale 1ns/1ps

module des_key_schedule
	import des_key_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic key_load,
	input logic key_decrypt,
	input user_key_t user_key,
	output logic keys_valid,
	output round_key_bank_t round_keys
);

	// Index 0 is the PC-1 stage, index k is round stage k
	cd_key_t cd_chain [0:round_count - 1];
	logic [0:round_count - 1] decrypt_chain;
	logic [0:round_count] valid_chain;
	round_key_bank_t stage_keys;  // Skewed, slot k one cycle behind slot k - 1

	key_select_pc1 u_key_select_pc1 (
		.clk(clk),
		.reset(reset),
		.key_load(key_load),
		.key_decrypt(key_decrypt),
		.user_key(user_key),
		.cd_out(cd_chain[0]),
		.decrypt_out(decrypt_chain[0]),
		.valid_out(valid_chain[0])
	);

	for (genvar i = 1; i <= round_count; i++) begin : g_round
		if (i < round_count) begin : g_mid
			key_round_stage #(
				.round(i)
			) u_key_round_stage (
				.clk(clk),
				.reset(reset),
				.cd_in(cd_chain[i - 1]),
				.decrypt_in(decrypt_chain[i - 1]),
				.valid_in(valid_chain[i - 1]),
				.cd_out(cd_chain[i]),
				.decrypt_out(decrypt_chain[i]),
				.valid_out(valid_chain[i]),
				.round_key(stage_keys[i])
			);
		end else begin : g_last
			// Nothing follows the last round, so its C, D and direction go nowhere
			key_round_stage #(
				.round(i)
			) u_key_round_stage (
				.clk(clk),
				.reset(reset),
				.cd_in(cd_chain[i - 1]),
				.decrypt_in(decrypt_chain[i - 1]),
				.valid_in(valid_chain[i - 1]),
				.cd_out(),
				.decrypt_out(),
				.valid_out(valid_chain[i]),
				.round_key(stage_keys[i])
			);
		end
	end

	round_key_collect u_round_key_collect (
		.clk(clk),
		.reset(reset),
		.stage_keys(stage_keys),
		.stage16_valid(valid_chain[round_count]),
		.round_keys(round_keys),
		.keys_valid(keys_valid)
	);

endmodule

// ==== test/des_key_schedule_chk.sv ====
`timescale 1ns/1ps

module des_key_schedule_chk (
	input logic clk,
	input logic reset,
	input logic key_load,
	input logic keys_valid
);

	localparam int latency = 17;

	// Every valid bit clears on a reset edge
	a_reset_low: assert property (@(posedge clk) $past(reset) |-> !keys_valid)
		else $error("keys_valid high in a reset cycle");

	a_after_reset_low: assert property (@(posedge clk) $past(reset, 2) |-> !keys_valid)
		else $error("keys_valid high in the cycle after reset");

	a_load_gives_bank: assert property (@(posedge clk) disable iff (reset)
		key_load |-> ##latency keys_valid)
		else $error("keys_valid missing 17 cycles after a load");

	// A bank only appears for a load that went in exactly 17 cycles before
	a_no_spurious_bank: assert property (@(posedge clk) disable iff (reset)
		keys_valid |-> $past(key_load, latency))
		else $error("keys_valid without a load 17 cycles earlier");

endmodule

bind des_key_schedule des_key_schedule_chk u_des_key_schedule_chk (
	.clk(clk),
	.reset(reset),
	.key_load(key_load),
	.keys_valid(keys_valid)
);

// ==== test/des_key_schedule_tb.sv ====
`timescale 1ns/1ps

module des_key_schedule_tb
	import des_key_types_pkg::*;
	import des_key_tables_pkg::*;
();

	localparam int entry_count = 16;
	localparam int timeout_cycles = 40;
	localparam int idle_cycles = 20;

	logic clk;
	logic reset;
	logic key_load;
	logic key_decrypt;
	user_key_t user_key;
	logic keys_valid;
	round_key_bank_t round_keys;

	// Stimulus table with one load per entry
	user_key_t tab_key [0:entry_count - 1];
	user_key_t tab_ref [0:entry_count - 1];    // Key that the expected bank comes from
	logic tab_dec [0:entry_count - 1];
	round_key_t tab_first [0:entry_count - 1];
	round_key_t tab_last [0:entry_count - 1];
	bit tab_burst [0:entry_count - 1];          // Next entry loads in the very next cycle
	string tab_name [0:entry_count - 1];

	// Scoreboard with one element per load still in flight
	round_key_bank_t exp_bank_q [$];
	int due_q [$];
	int idx_q [$];

	int seed = 32'hcf0c_af05;
	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	bit monitor_on = 1'b0;

	des_key_schedule u_des_key_schedule (
		.clk(clk),
		.reset(reset),
		.key_load(key_load),
		.key_decrypt(key_decrypt),
		.user_key(user_key),
		.keys_valid(keys_valid),
		.round_keys(round_keys)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// Textbook schedule with PC-1, running left rotations, then PC-2 per round
	function automatic round_key_bank_t model_bank(input user_key_t key);
		cd_key_t cd;
		logic [1:half_width] c;
		logic [1:half_width] d;
		round_key_bank_t bank;
		for (int i = 1; i <= cd_width; i++) begin
			cd[i] = key[pc1_table[i]];
		end
		c = cd[1:half_width];
		d = cd[half_width + 1:cd_width];
		for (int r = 1; r <= round_count; r++) begin
			for (int s = 0; s < enc_shift_table[r]; s++) begin
				c = {c[2:half_width], c[1]};
				d = {d[2:half_width], d[1]};
			end
			cd = {c, d};
			for (int i = 1; i <= round_key_width; i++) begin
				bank[r][i] = cd[pc2_table[i]];
			end
		end
		return bank;
	endfunction

	function automatic round_key_bank_t reverse_bank(input round_key_bank_t bank);
		round_key_bank_t rev;
		for (int r = 1; r <= round_count; r++) begin
			rev[r] = bank[round_count + 1 - r];
		end
		return rev;
	endfunction

	task automatic compare_bank(input round_key_bank_t got, input round_key_bank_t exp,
			input string name);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic compare_key(input round_key_t got, input round_key_t exp, input string name);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic compare_valid(input logic got, input logic exp, input string name);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d %s: pass", test_count, name);
		end else begin
			$display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
		end
	endtask

	task automatic build_table();
		user_key_t kat_key;
		user_key_t flipped;
		round_key_t kat_k1;
		round_key_t kat_k16;
		round_key_bank_t bank;
		kat_key = 64'h1334_5779_9bbc_dff1;
		kat_k1 = 48'h1b02_effc_7072;
		kat_k16 = 48'hcb3d_8b0e_17f5;
		for (int i = 0; i < 2; i++) begin
			tab_key[i] = kat_key;
			tab_ref[i] = kat_key;
			tab_dec[i] = (i == 1);
			tab_first[i] = (i == 1) ? kat_k16 : kat_k1;
			tab_last[i] = (i == 1) ? kat_k1 : kat_k16;
			tab_burst[i] = 1'b0;
			tab_name[i] = (i == 1) ? "known answer decrypt" : "known answer encrypt";
		end
		// Random keys go in back to back with alternating direction
		for (int i = 2; i < 8; i++) begin
			tab_key[i] = {$random(seed), $random(seed)};
			tab_ref[i] = tab_key[i];
			tab_dec[i] = i[0];
			bank = model_bank(tab_key[i]);
			if (tab_dec[i]) begin
				bank = reverse_bank(bank);
			end
			tab_first[i] = bank[1];
			tab_last[i] = bank[round_count];
			tab_burst[i] = (i != 7);
			tab_name[i] = tab_dec[i] ? "random decrypt" : "random encrypt";
		end
		for (int p = 1; p <= 8; p++) begin
			flipped = kat_key;
			flipped[8 * p] = ~flipped[8 * p];  // Parity sits in the last bit of each byte
			tab_key[p + 7] = flipped;
			tab_ref[p + 7] = kat_key;
			tab_dec[p + 7] = p[0];
			tab_first[p + 7] = p[0] ? kat_k16 : kat_k1;
			tab_last[p + 7] = p[0] ? kat_k1 : kat_k16;
			tab_burst[p + 7] = (p != 8);
			tab_name[p + 7] = $sformatf("parity bit %0d flipped", 8 * p);
		end
	endtask

	task automatic load_key(input int idx);
		round_key_bank_t bank;
		@(posedge clk);
		key_load <= 1'b1;
		key_decrypt <= tab_dec[idx];
		user_key <= tab_key[idx];
		bank = model_bank(tab_ref[idx]);
		if (tab_dec[idx]) begin
			bank = reverse_bank(bank);
		end
		exp_bank_q.push_back(bank);
		due_q.push_back(cycle_count + 18);  // Sampled at the next edge, bank 17 edges later
		idx_q.push_back(idx);
	endtask

	task automatic end_load();
		@(posedge clk);
		key_load <= 1'b0;
	endtask

	task automatic wait_drain(input int idx);
		int waited;
		waited = 0;
		while (exp_bank_q.size() != 0 && waited < timeout_cycles) begin
			@(posedge clk);
			waited++;
		end
		if (exp_bank_q.size() != 0) begin
			error_count++;
			$display("Timed out after %0d cycles waiting for the bank of entry %0d",
				timeout_cycles, idx);
			exp_bank_q.delete();
			due_q.delete();
			idx_q.delete();
		end
	endtask

	// Outputs are sampled at the falling edge, half a cycle after they settle
	always @(negedge clk) begin : monitor
		int errors_before;
		int idx;
		logic expect_now;
		round_key_bank_t exp_bank;
		if (monitor_on) begin
			errors_before = error_count;
			expect_now = 1'b0;
			if (due_q.size() != 0) begin
				expect_now = (due_q[0] == cycle_count);
			end
			compare_valid(keys_valid, expect_now, "keys_valid");
			if (expect_now) begin
				exp_bank = exp_bank_q.pop_front();
				void'(due_q.pop_front());
				idx = idx_q.pop_front();
				if (keys_valid === 1'b1) begin
					compare_bank(round_keys, exp_bank, "round_keys");
					compare_key(round_keys[1], tab_first[idx], "round_keys[1]");
					compare_key(round_keys[round_count], tab_last[idx], "round_keys[16]");
				end
				report_test(tab_name[idx], errors_before);
			end
		end
	end

	initial begin : main
		int idle_mark;
		key_load = 1'b0;
		key_decrypt = 1'b0;
		user_key = '0;
		reset = 1'b1;
		build_table();
		@(posedge clk);
		monitor_on = 1'b1;
		repeat (9) @(posedge clk);
		reset <= 1'b0;
		// With no load yet the monitor expects keys_valid to stay low
		idle_mark = error_count;
		repeat (idle_cycles) @(posedge clk);
		report_test("reset and idle", idle_mark);
		for (int i = 0; i < entry_count; i++) begin
			load_key(i);
			if (!tab_burst[i]) begin
				end_load();
				wait_drain(i);
			end
		end
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
src/des_key_types_pkg.sv
src/des_key_tables_pkg.sv
src/key_select_pc1.sv
src/key_round_stage.sv
src/round_key_collect.sv
src/des_key_schedule.sv
test/des_key_schedule_chk.sv
test/des_key_schedule_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= des_key_schedule_tb
RTL_TOP ?= des_key_schedule
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --timing --assert
FAIL_MSG ?= Testbench failed
PASS_MSG ?= Testbench passed

SOURCES := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter src/%,$(SOURCES))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SOURCES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
